// ==== hw/soc_params.svh ====
// Peripheral subsystem parameters

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_AXI_ADDR_W      16
`define SOC_DATA_W          32
`define SOC_SEL_W           4
`define SOC_WB_ADR_W        14

// Region select sits in word-address bits 9:8
`define SOC_REGION_LSB      8
`define SOC_REGION_FLAG     2'd0
`define SOC_REGION_LED      2'd1
`define SOC_REGION_TIMER    2'd2

// Register word offsets
`define FLG_PTN             2'd0
`define FLG_CLR             2'd1
`define FLG_WAI             2'd2
`define FLG_MODE            2'd3
`define TIM_CTRL            2'd0
`define TIM_CMP             2'd1
`define TIM_CNT             2'd2
`define LED_REG             2'd0

`endif

// ==== hw/soc_pkg.sv ====
// Internal bus types

`include "soc_params.svh"

`default_nettype none

package soc_pkg;

    // ----------------------------------------
    // Request from the bridge
    // ----------------------------------------
    typedef struct packed {
        logic [`SOC_WB_ADR_W-1:0] adr;
        logic [`SOC_DATA_W-1:0]   dat;
        logic                     we;
        logic [`SOC_SEL_W-1:0]    sel;
        logic                     stb;
    } wb_req_t;

    // ----------------------------------------
    // Response back to the bridge
    // ----------------------------------------
    // Ack is returned in the strobe cycle
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] dat;
        logic                   ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/axi4l_to_wb.sv ====
// AXI4-Lite to internal bus bridge

`include "soc_params.svh"

`default_nettype none

module axi4l_to_wb (
    input  wire logic                        clk,
    input  wire logic                        reset,

    input  wire logic [`SOC_AXI_ADDR_W-1:0]  s_axi_awaddr_i,
    input  wire logic                        s_axi_awvalid_i,
    output logic                             s_axi_awready_o,
    input  wire logic [`SOC_DATA_W-1:0]      s_axi_wdata_i,
    input  wire logic [`SOC_SEL_W-1:0]       s_axi_wstrb_i,
    input  wire logic                        s_axi_wvalid_i,
    output logic                             s_axi_wready_o,
    output logic [1:0]                       s_axi_bresp_o,
    output logic                             s_axi_bvalid_o,
    input  wire logic                        s_axi_bready_i,
    input  wire logic [`SOC_AXI_ADDR_W-1:0]  s_axi_araddr_i,
    input  wire logic                        s_axi_arvalid_i,
    output logic                             s_axi_arready_o,
    output logic [`SOC_DATA_W-1:0]           s_axi_rdata_o,
    output logic [1:0]                       s_axi_rresp_o,
    output logic                             s_axi_rvalid_o,
    input  wire logic                        s_axi_rready_i,

    output soc_pkg::wb_req_t                 wb_req_o,
    input  soc_pkg::wb_rsp_t                 wb_rsp_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STB,
        S_WRSP,
        S_RRSP
    } state_t;

    state_t                    state_q;
    logic                      wr_go;
    logic                      rd_go;
    logic [`SOC_WB_ADR_W-1:0]  adr_q;
    logic [`SOC_DATA_W-1:0]    dat_q;
    logic [`SOC_SEL_W-1:0]     sel_q;
    logic                      we_q;
    logic [`SOC_DATA_W-1:0]    rdata_q;

    // ----------------------------------------
    // Accept logic
    // ----------------------------------------
    // Write needs both address and data; a write request blocks reads
    assign wr_go = (state_q == S_IDLE) && s_axi_awvalid_i && s_axi_wvalid_i;
    assign rd_go = (state_q == S_IDLE) && s_axi_arvalid_i
                   && !s_axi_awvalid_i && !s_axi_wvalid_i;

    assign s_axi_awready_o = wr_go;
    assign s_axi_wready_o  = wr_go;
    assign s_axi_arready_o = rd_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (wr_go || rd_go) begin
                        state_q <= S_STB;
                    end
                end
                S_STB: begin
                    if (wb_rsp_i.ack) begin
                        state_q <= we_q ? S_WRSP : S_RRSP;
                    end
                end
                S_WRSP: begin
                    if (s_axi_bready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    if (s_axi_rready_i) begin
                        state_q <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Captured transaction, byte offset dropped
    always_ff @(posedge clk) begin
        if (wr_go) begin
            adr_q <= s_axi_awaddr_i[`SOC_AXI_ADDR_W-1:2];
            dat_q <= s_axi_wdata_i;
            sel_q <= s_axi_wstrb_i;
            we_q  <= 1'b1;
        end else if (rd_go) begin
            adr_q <= s_axi_araddr_i[`SOC_AXI_ADDR_W-1:2];
            sel_q <= '1;
            we_q  <= 1'b0;
        end
    end

    // Read data sampled at the acknowledge
    always_ff @(posedge clk) begin
        if (state_q == S_STB && wb_rsp_i.ack && !we_q) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    assign wb_req_o = '{adr: adr_q, dat: dat_q, we: we_q, sel: sel_q,
                        stb: (state_q == S_STB)};

    // ----------------------------------------
    // Response channels
    // ----------------------------------------
    assign s_axi_bvalid_o = (state_q == S_WRSP);
    assign s_axi_bresp_o  = 2'b00;
    assign s_axi_rvalid_o = (state_q == S_RRSP);
    assign s_axi_rresp_o  = 2'b00;
    assign s_axi_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== hw/wb_decoder.sv ====
// Internal bus region decoder

`include "soc_params.svh"

`default_nettype none

module wb_decoder (
    input  soc_pkg::wb_req_t  wb_req_i,
    output soc_pkg::wb_req_t  flag_req_o,
    output soc_pkg::wb_req_t  led_req_o,
    output soc_pkg::wb_req_t  tim_req_o,
    input  soc_pkg::wb_rsp_t  flag_rsp_i,
    input  soc_pkg::wb_rsp_t  led_rsp_i,
    input  soc_pkg::wb_rsp_t  tim_rsp_i,
    output soc_pkg::wb_rsp_t  wb_rsp_o
);

    logic [1:0] region;

    assign region = wb_req_i.adr[`SOC_REGION_LSB +: 2];

    // Same request everywhere, only the strobe is qualified
    always_comb begin
        flag_req_o     = wb_req_i;
        led_req_o      = wb_req_i;
        tim_req_o      = wb_req_i;
        flag_req_o.stb = wb_req_i.stb && (region == `SOC_REGION_FLAG);
        led_req_o.stb  = wb_req_i.stb && (region == `SOC_REGION_LED);
        tim_req_o.stb  = wb_req_i.stb && (region == `SOC_REGION_TIMER);
    end

    // Response select
    always_comb begin
        case (region)
            `SOC_REGION_FLAG:  wb_rsp_o = flag_rsp_i;
            `SOC_REGION_LED:   wb_rsp_o = led_rsp_i;
            `SOC_REGION_TIMER: wb_rsp_o = tim_rsp_i;
            default: begin
                // Unmapped, ack with zero data
                wb_rsp_o.dat = '0;
                wb_rsp_o.ack = wb_req_i.stb;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/event_flag.sv ====
// Event flag unit

`include "soc_params.svh"

`default_nettype none

module event_flag (
    input  wire logic         clk,
    input  wire logic         reset,
    input  soc_pkg::wb_req_t  req_i,
    output soc_pkg::wb_rsp_t  rsp_o,
    output logic              irq_o
);

    logic [`SOC_DATA_W-1:0] ptn_q;
    logic [`SOC_DATA_W-1:0] wai_q;
    logic                   mode_q;
    logic [`SOC_DATA_W-1:0] byte_mask;
    logic [`SOC_DATA_W-1:0] hit;
    logic                   wr;

    assign wr = req_i.stb && req_i.we;

    always_comb begin
        for (int i = 0; i < `SOC_SEL_W; i++) begin
            byte_mask[8*i +: 8] = {8{req_i.sel[i]}};
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ptn_q  <= '0;
            wai_q  <= '0;
            mode_q <= 1'b0;
        end else if (wr) begin
            case (req_i.adr[1:0])
                // Set by OR
                `FLG_PTN: ptn_q <= ptn_q | (req_i.dat & byte_mask);
                // Clear by AND, unselected bytes kept
                `FLG_CLR: ptn_q <= ptn_q & (req_i.dat | ~byte_mask);
                `FLG_WAI: wai_q <= (wai_q & ~byte_mask) | (req_i.dat & byte_mask);
                default: begin
                    if (req_i.sel[0]) begin
                        mode_q <= req_i.dat[0];
                    end
                end
            endcase
        end
    end

    // Read back, the clear register reads as zero
    always_comb begin
        case (req_i.adr[1:0])
            `FLG_PTN: rsp_o.dat = ptn_q;
            `FLG_WAI: rsp_o.dat = wai_q;
            `FLG_MODE: rsp_o.dat = {{(`SOC_DATA_W-1){1'b0}}, mode_q};
            default: rsp_o.dat = '0;
        endcase
    end

    assign rsp_o.ack = req_i.stb;

    // Wait condition, AND mode never fires on an empty mask
    assign hit   = ptn_q & wai_q;
    assign irq_o = mode_q ? ((wai_q != '0) && (hit == wai_q)) : (hit != '0);

endmodule

`default_nettype wire

// ==== hw/interval_timer.sv ====
// Interval timer

`include "soc_params.svh"

`default_nettype none

module interval_timer (
    input  wire logic         clk,
    input  wire logic         reset,
    input  soc_pkg::wb_req_t  req_i,
    output soc_pkg::wb_rsp_t  rsp_o,
    output logic              irq_o
);

    logic                   en_q;
    logic                   sts_q;
    logic [`SOC_DATA_W-1:0] cmp_q;
    logic [`SOC_DATA_W-1:0] cnt_q;
    logic [`SOC_DATA_W-1:0] byte_mask;
    logic                   wr;
    logic                   ctrl_wr;
    logic                   match;

    assign wr      = req_i.stb && req_i.we;
    assign ctrl_wr = wr && (req_i.adr[1:0] == `TIM_CTRL) && req_i.sel[0];
    assign match   = en_q && (cnt_q == cmp_q);

    always_comb begin
        for (int i = 0; i < `SOC_SEL_W; i++) begin
            byte_mask[8*i +: 8] = {8{req_i.sel[i]}};
        end
    end

    // ----------------------------------------
    // Counter
    // ----------------------------------------
    // Period is compare plus one
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_q <= '0;
        end else if (match) begin
            cnt_q <= '0;
        end else if (en_q) begin
            cnt_q <= cnt_q + 32'd1;
        end
    end

    // ----------------------------------------
    // Control and status
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            en_q  <= 1'b0;
            sts_q <= 1'b0;
            cmp_q <= '0;
        end else begin
            if (ctrl_wr) begin
                en_q <= req_i.dat[0];
            end
            // New match wins over a clear in the same cycle
            if (match) begin
                sts_q <= 1'b1;
            end else if (ctrl_wr && req_i.dat[1]) begin
                sts_q <= 1'b0;
            end
            if (wr && req_i.adr[1:0] == `TIM_CMP) begin
                cmp_q <= (cmp_q & ~byte_mask) | (req_i.dat & byte_mask);
            end
        end
    end

    always_comb begin
        case (req_i.adr[1:0])
            `TIM_CTRL: rsp_o.dat = {{(`SOC_DATA_W-2){1'b0}}, sts_q, en_q};
            `TIM_CMP:  rsp_o.dat = cmp_q;
            `TIM_CNT:  rsp_o.dat = cnt_q;
            default:   rsp_o.dat = '0;
        endcase
    end

    assign rsp_o.ack = req_i.stb;
    assign irq_o     = sts_q;

endmodule

`default_nettype wire

// ==== hw/led_ctrl.sv ====
// LED register and blinker

`include "soc_params.svh"

`default_nettype none

module led_ctrl #(
    parameter int BLINK_W = 26
) (
    input  wire logic         clk,
    input  wire logic         reset,
    input  soc_pkg::wb_req_t  req_i,
    output soc_pkg::wb_rsp_t  rsp_o,
    output logic [1:0]        led_o
);

    logic               led_q;
    logic [BLINK_W-1:0] cnt_q;
    logic               at_reg;

    assign at_reg = (req_i.adr[1:0] == `LED_REG);

    always_ff @(posedge clk) begin
        if (reset) begin
            led_q <= 1'b0;
            cnt_q <= '0;
        end else begin
            // Free-running blink count
            cnt_q <= cnt_q + 1'b1;
            if (req_i.stb && req_i.we && at_reg && req_i.sel[0]) begin
                led_q <= req_i.dat[0];
            end
        end
    end

    assign rsp_o.dat = {{(`SOC_DATA_W-1){1'b0}}, at_reg & led_q};
    assign rsp_o.ack = req_i.stb;
    assign led_o     = {cnt_q[BLINK_W-1], led_q};

endmodule

`default_nettype wire

// ==== hw/rtos_soc_top.sv ====
// Peripheral subsystem top

`include "soc_params.svh"

`default_nettype none

module rtos_soc_top #(
    parameter int BLINK_W = 26
) (
    input  wire logic                        clk,
    input  wire logic                        reset,

    input  wire logic [`SOC_AXI_ADDR_W-1:0]  s_axi_awaddr_i,
    input  wire logic                        s_axi_awvalid_i,
    output logic                             s_axi_awready_o,
    input  wire logic [`SOC_DATA_W-1:0]      s_axi_wdata_i,
    input  wire logic [`SOC_SEL_W-1:0]       s_axi_wstrb_i,
    input  wire logic                        s_axi_wvalid_i,
    output logic                             s_axi_wready_o,
    output logic [1:0]                       s_axi_bresp_o,
    output logic                             s_axi_bvalid_o,
    input  wire logic                        s_axi_bready_i,
    input  wire logic [`SOC_AXI_ADDR_W-1:0]  s_axi_araddr_i,
    input  wire logic                        s_axi_arvalid_i,
    output logic                             s_axi_arready_o,
    output logic [`SOC_DATA_W-1:0]           s_axi_rdata_o,
    output logic [1:0]                       s_axi_rresp_o,
    output logic                             s_axi_rvalid_o,
    input  wire logic                        s_axi_rready_i,

    output logic [1:0]                       led_o,
    output logic                             flag_irq_o,
    output logic                             tim_irq_o
);

    import soc_pkg::*;

    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    wb_req_t flag_req;
    wb_req_t led_req;
    wb_req_t tim_req;
    wb_rsp_t flag_rsp;
    wb_rsp_t led_rsp;
    wb_rsp_t tim_rsp;

    // ----------------------------------------
    // Bus bridge and decode
    // ----------------------------------------
    axi4l_to_wb i_bridge (
        .clk             (clk),
        .reset           (reset),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .wb_req_o        (bus_req),
        .wb_rsp_i        (bus_rsp)
    );

    wb_decoder i_decoder (
        .wb_req_i   (bus_req),
        .flag_req_o (flag_req),
        .led_req_o  (led_req),
        .tim_req_o  (tim_req),
        .flag_rsp_i (flag_rsp),
        .led_rsp_i  (led_rsp),
        .tim_rsp_i  (tim_rsp),
        .wb_rsp_o   (bus_rsp)
    );

    // ----------------------------------------
    // Peripherals
    // ----------------------------------------
    event_flag i_event_flag (
        .clk   (clk),
        .reset (reset),
        .req_i (flag_req),
        .rsp_o (flag_rsp),
        .irq_o (flag_irq_o)
    );

    interval_timer i_timer (
        .clk   (clk),
        .reset (reset),
        .req_i (tim_req),
        .rsp_o (tim_rsp),
        .irq_o (tim_irq_o)
    );

    led_ctrl #(
        .BLINK_W (BLINK_W)
    ) i_led (
        .clk   (clk),
        .reset (reset),
        .req_i (led_req),
        .rsp_o (led_rsp),
        .led_o (led_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_rtos_soc.sv ====
// Peripheral subsystem testbench

`include "soc_params.svh"

`default_nettype none

module tb_rtos_soc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RAND     = 300;
    localparam int NUM_TIM      = 6;
    localparam int WATCHDOG_CYC = (NUM_RAND + 6 * NUM_TIM + 4) * 20 + NUM_TIM * 63 + 200;
    localparam logic [15:0] LFSR_POLY = 16'hB400;

    logic                        clk;
    logic                        reset;
    logic [`SOC_AXI_ADDR_W-1:0]  awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [`SOC_DATA_W-1:0]      wdata;
    logic [`SOC_SEL_W-1:0]       wstrb;
    logic                        wvalid;
    logic                        wready;
    logic [1:0]                  bresp;
    logic                        bvalid;
    logic                        bready;
    logic [`SOC_AXI_ADDR_W-1:0]  araddr;
    logic                        arvalid;
    logic                        arready;
    logic [`SOC_DATA_W-1:0]      rdata;
    logic [1:0]                  rresp;
    logic                        rvalid;
    logic                        rready;
    logic [1:0]                  led;
    logic                        flag_irq;
    logic                        tim_irq;

    // Reference model state
    logic [31:0] m_ptn;
    logic [31:0] m_wai;
    logic [31:0] m_cmp;
    logic [31:0] m_cnt;
    logic [31:0] m_rd;
    logic        m_mode;
    logic        m_en;
    logic        m_sts;
    logic        m_led;
    logic [3:0]  m_blink;
    logic        rst_prev = 1'b1;
    logic        model_live = 1'b0;

    // Responses seen on the B and R channels
    int          wr_rsp_cnt = 0;
    int          rd_rsp_cnt = 0;
    logic        bvalid_prev = 1'b0;
    logic        rvalid_prev = 1'b0;

    // Accepted transaction handed to the model
    int          op_stage = 0;
    logic        op_we;
    logic [13:0] op_adr;
    logic [31:0] op_dat;
    logic [3:0]  op_sel;
    int          txn_wr = 0;
    int          txn_rd = 0;

    logic [15:0] lfsr_q = 16'd15909;

    rtos_soc_top #(
        .BLINK_W (4)
    ) i_dut (
        .clk             (clk),
        .reset           (reset),
        .s_axi_awaddr_i  (awaddr),
        .s_axi_awvalid_i (awvalid),
        .s_axi_awready_o (awready),
        .s_axi_wdata_i   (wdata),
        .s_axi_wstrb_i   (wstrb),
        .s_axi_wvalid_i  (wvalid),
        .s_axi_wready_o  (wready),
        .s_axi_bresp_o   (bresp),
        .s_axi_bvalid_o  (bvalid),
        .s_axi_bready_i  (bready),
        .s_axi_araddr_i  (araddr),
        .s_axi_arvalid_i (arvalid),
        .s_axi_arready_o (arready),
        .s_axi_rdata_o   (rdata),
        .s_axi_rresp_o   (rresp),
        .s_axi_rvalid_o  (rvalid),
        .s_axi_rready_i  (rready),
        .led_o           (led),
        .flag_irq_o      (flag_irq),
        .tim_irq_o       (tim_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_POLY) : (lfsr_q >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] sel_to_mask(input logic [3:0] sel);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{sel[i]}};
        end
        return m;
    endfunction

    // Region sits in byte-address bits 11:10 and the register in bits 3:2
    function automatic logic [15:0] reg_addr(input logic [1:0] rgn, input logic [1:0] off);
        return {4'd0, rgn, 6'd0, off, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "Check %s did not match", name);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic flag_wait_met();
        if (m_mode) begin
            return (m_wai != '0) && ((m_ptn & m_wai) == m_wai);
        end
        return (m_ptn & m_wai) != '0;
    endfunction

    function automatic logic [31:0] expected_read(input logic [13:0] adr);
        logic [1:0] off;
        off = adr[1:0];
        case (adr[9:8])
            `SOC_REGION_FLAG: begin
                if (off == `FLG_PTN) return m_ptn;
                if (off == `FLG_WAI) return m_wai;
                if (off == `FLG_MODE) return {31'd0, m_mode};
            end
            `SOC_REGION_LED: begin
                if (off == `LED_REG) return {31'd0, m_led};
            end
            `SOC_REGION_TIMER: begin
                if (off == `TIM_CTRL) return {30'd0, m_sts, m_en};
                if (off == `TIM_CMP) return m_cmp;
                if (off == `TIM_CNT) return m_cnt;
            end
            default: begin
            end
        endcase
        return '0;
    endfunction

    task automatic reset_model();
        m_ptn   = '0;
        m_wai   = '0;
        m_mode  = 1'b0;
        m_led   = 1'b0;
        m_blink = '0;
        m_en    = 1'b0;
        m_sts   = 1'b0;
        m_cmp   = '0;
        m_cnt   = '0;
    endtask

    // One clock edge of the model with the op applied one edge after acceptance
    task automatic step_model();
        logic        match;
        logic        en_pre;
        logic        clr_req;
        logic [1:0]  off;
        logic [31:0] bm;
        match   = m_en && (m_cnt == m_cmp);
        en_pre  = m_en;
        clr_req = 1'b0;
        off     = op_adr[1:0];
        bm      = sel_to_mask(op_sel);
        if (op_stage == 2 && !op_we) begin
            m_rd = expected_read(op_adr);
        end else if (op_stage == 2) begin
            case (op_adr[9:8])
                `SOC_REGION_FLAG: begin
                    if (off == `FLG_PTN) m_ptn = m_ptn | (op_dat & bm);
                    if (off == `FLG_CLR) m_ptn = m_ptn & ~(~op_dat & bm);
                    if (off == `FLG_WAI) m_wai = (m_wai & ~bm) | (op_dat & bm);
                    if (off == `FLG_MODE && op_sel[0]) m_mode = op_dat[0];
                end
                `SOC_REGION_LED: begin
                    if (off == `LED_REG && op_sel[0]) m_led = op_dat[0];
                end
                `SOC_REGION_TIMER: begin
                    if (off == `TIM_CTRL && op_sel[0]) begin
                        m_en    = op_dat[0];
                        clr_req = op_dat[1];
                    end
                    if (off == `TIM_CMP) m_cmp = (m_cmp & ~bm) | (op_dat & bm);
                end
                default: begin
                    // Unmapped region changes nothing
                end
            endcase
        end
        if (match) begin
            m_cnt = '0;
        end else if (en_pre) begin
            m_cnt = m_cnt + 32'd1;
        end
        // A new match beats a clear
        if (match) begin
            m_sts = 1'b1;
        end else if (clr_req) begin
            m_sts = 1'b0;
        end
        m_blink = m_blink + 4'd1;
        op_stage = (op_stage == 1) ? 2 : 0;
    endtask

    // Model steps on the falling edge and checks the outputs every cycle
    always @(negedge clk) begin
        if (rst_prev) begin
            reset_model();
            model_live = 1'b1;
        end else if (model_live) begin
            step_model();
        end
        rst_prev = reset;
        if (model_live) begin
            check_value("flag_irq", 32'(flag_wait_met()), 32'(flag_irq));
            check_value("tim_irq", 32'(m_sts), 32'(tim_irq));
            check_value("led", 32'({m_blink[3], m_led}), 32'(led));
        end
        // Each rising valid is one response from the DUT
        if (bvalid && !bvalid_prev) begin
            wr_rsp_cnt++;
        end
        if (rvalid && !rvalid_prev) begin
            rd_rsp_cnt++;
        end
        bvalid_prev = bvalid;
        rvalid_prev = rvalid;
    end

    // ----------------------------------------
    // AXI master
    // ----------------------------------------
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        int delay;
        txn_wr++;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        op_we    = 1'b1;
        op_adr   = addr[15:2];
        op_dat   = data;
        op_sel   = strb;
        op_stage = 1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_value("bresp", 32'd0, 32'(bresp));
        delay = int'(rand_bits(2));
        repeat (delay) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input string name, input logic [15:0] addr,
                            output logic [31:0] data);
        int delay;
        txn_rd++;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        op_we    = 1'b0;
        op_adr   = addr[15:2];
        op_dat   = '0;
        op_sel   = 4'hF;
        op_stage = 1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        delay = int'(rand_bits(2));
        // Model read value is settled by the next rising edge
        @(posedge clk);
        check_value(name, m_rd, rdata);
        check_value("rresp", 32'd0, 32'(rresp));
        data = rdata;
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] cmp;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  rgn;
        logic [1:0]  off;
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Timer periods with compare kept at or above the frozen count
        for (int i = 0; i < NUM_TIM; i++) begin
            write_reg(reg_addr(`SOC_REGION_TIMER, `TIM_CTRL), 32'd2, 4'hF);
            read_reg("tim_cnt_frozen", reg_addr(`SOC_REGION_TIMER, `TIM_CNT), rd);
            read_reg("tim_cnt_frozen", reg_addr(`SOC_REGION_TIMER, `TIM_CNT), rd);
            cmp = 32'd2 + (rand_bits(5) % 32'd19);
            if (cmp < rd) cmp = rd;
            write_reg(reg_addr(`SOC_REGION_TIMER, `TIM_CMP), cmp, 4'hF);
            write_reg(reg_addr(`SOC_REGION_TIMER, `TIM_CTRL), 32'd1, 4'h1);
            // Let a few periods run under the per-cycle check
            repeat (3 * (cmp + 1)) @(posedge clk);
            read_reg("tim_cnt_run", reg_addr(`SOC_REGION_TIMER, `TIM_CNT), rd);
        end

        // Random traffic over all regions
        for (int i = 0; i < NUM_RAND; i++) begin
            rgn  = 2'(rand_bits(2));
            off  = 2'(rand_bits(2));
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            if (rand_bits(1) == 32'd1) rgn = `SOC_REGION_FLAG;
            // Sparse wait masks so both wait modes fire
            if (rgn == `SOC_REGION_FLAG && off == `FLG_WAI) data = data & rand_bits(32);
            if (rand_bits(1) == 32'd1) begin
                if (rgn == `SOC_REGION_TIMER) off = `TIM_CTRL;
                write_reg(reg_addr(rgn, off), data, strb);
            end else begin
                read_reg("rand_read", reg_addr(rgn, off), rd);
            end
        end

        // AND mode with an empty mask
        write_reg(reg_addr(`SOC_REGION_FLAG, `FLG_WAI), 32'd0, 4'hF);
        write_reg(reg_addr(`SOC_REGION_FLAG, `FLG_MODE), 32'd1, 4'hF);
        read_reg("flag_mode", reg_addr(`SOC_REGION_FLAG, `FLG_MODE), rd);
        read_reg("flag_ptn", reg_addr(`SOC_REGION_FLAG, `FLG_PTN), rd);

        check_value("write_count", 32'(txn_wr), 32'(wr_rsp_cnt));
        check_value("read_count", 32'(txn_rd), 32'(rd_rsp_cnt));
        $display("Test OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired before all transactions completed");
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/soc_pkg.sv
hw/axi4l_to_wb.sv
hw/wb_decoder.sv
hw/event_flag.sv
hw/interval_timer.sv
hw/led_ctrl.sv
hw/rtos_soc_top.sv
verification/tb_rtos_soc.sv

// ==== Makefile ====
TOP := tb_rtos_soc

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f project.f --top-module rtos_soc_top

clean:
	rm -rf obj_dir
